// File: design/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

`default_nettype none

// ---------------------------------------------------------------------------
// fetch front-end build constants
// ---------------------------------------------------------------------------

`define FETCH_RESET_PC 32'h1c000000 // first fetch address out of reset.

`define FETCH_BTB_ENTRIES 64 // must stay a power of two.

`define FETCH_GROUP_SLOTS 4 // a group carries this many instructions in 128 bits.

`default_nettype wire

`endif

// File: design/fetch_pkg.sv
`include "fetch_settings.svh"
`default_nettype none

package fetch_pkg;

  // the group geometry follows from the slot count.
  localparam int unsigned SLOTS = `FETCH_GROUP_SLOTS;
  localparam int unsigned GROUP_BYTES = SLOTS * 4; // 16 bytes per group.
  localparam int unsigned SLOT_SEL_W = $clog2(SLOTS); // word offset within a group.

  typedef logic [SLOTS-1:0] slot_mask_t; // bit i belongs to slot i.

  typedef logic [SLOTS*32-1:0] group_data_t; // slot 0 sits in the low word.

  typedef enum logic [1:0] {
    S_IDLE = 2'd0,
    S_WAIT = 2'd1,
    S_HOLD = 2'd2,
    S_DROP = 2'd3
  } if1_state_t;

endpackage

`default_nettype wire

// File: design/excp_pkg.sv
`default_nettype none

package excp_pkg;

  // LoongArch exception codes seen by the fetch stages.
  typedef enum logic [5:0] {
    E_NONE = 6'h00,
    E_ADEF = 6'h08 // fetch address error.
  } ecode_t;

  typedef logic [8:0] subcode_t; // always zero for fetch.

endpackage

`default_nettype wire

// File: design/if_stage0.sv
`include "fetch_settings.svh"
`timescale 1ns/100ps
`default_nettype none

module if_stage0 (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush,
  input  logic                  need_jump,
  input  logic [31:0]           jump_pc,
  input  logic                  addr_ok,
  input  logic                  if1_ready,
  input  fetch_pkg::slot_mask_t pc_is_jump,
  input  fetch_pkg::slot_mask_t pc_valid,
  input  logic [31:0]           pre_nextpc,
  output logic                  req,
  output logic [31:0]           addr,
  output logic [31:0]           pc_to_bpu,
  output logic                  if0_valid,
  output logic [31:0]           if0_pc,
  output fetch_pkg::slot_mask_t if0_slot_valid,
  output fetch_pkg::slot_mask_t if0_is_jump,
  output excp_pkg::ecode_t      if0_ecode,
  output excp_pkg::subcode_t    if0_subcode
);

  logic [31:0] pc_r;
  logic        is_adef;
  logic        can_issue;
  logic        bypass;
  logic        advance;

  assign is_adef = |pc_r[1:0];

  // only one group may be outstanding, so the stage-0 register must be empty.
  assign can_issue = ~rst & ~flush & ~need_jump & if1_ready & ~if0_valid;

  assign req     = can_issue & ~is_adef;
  assign bypass  = can_issue & is_adef; // misaligned pc skips the cache.
  assign advance = (req & addr_ok) | bypass;

  assign addr      = pc_r;
  assign pc_to_bpu = pc_r;

  // --------------------------------------------------------------------------
  // program counter
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_r <= `FETCH_RESET_PC;
    end else if (need_jump) begin
      pc_r <= jump_pc;
    end else if (advance) begin
      pc_r <= pre_nextpc; // predictor picks the next group.
    end
  end

  // --------------------------------------------------------------------------
  // stage-0 to stage-1 register
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst | flush) begin
      if0_valid <= 1'b0;
    end else if (advance) begin
      if0_valid <= 1'b1;
    end else if (if1_ready) begin
      if0_valid <= 1'b0; // stage 1 has taken the group.
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      if0_pc         <= pc_r;
      if0_slot_valid <= pc_valid;
      if0_is_jump    <= pc_is_jump;
      if0_ecode      <= is_adef ? excp_pkg::E_ADEF : excp_pkg::E_NONE;
      if0_subcode    <= '0;
    end
  end

endmodule

`default_nettype wire

// File: design/branch_predictor.sv
`include "fetch_settings.svh"
`timescale 1ns/100ps
`default_nettype none

module branch_predictor (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [31:0]           pc,
  input  logic                  update_valid,
  input  logic [31:0]           update_pc,
  input  logic [31:0]           update_target,
  input  logic                  update_taken,
  output fetch_pkg::slot_mask_t is_jump,
  output fetch_pkg::slot_mask_t slot_valid,
  output logic [31:0]           next_pc
);

  localparam int unsigned ENTRIES = `FETCH_BTB_ENTRIES;
  localparam int unsigned IDX_W   = $clog2(ENTRIES);
  localparam int unsigned TAG_W   = 30 - IDX_W; // word address minus index.
  localparam int unsigned SLOTS   = fetch_pkg::SLOTS;
  localparam int unsigned OFF_W   = fetch_pkg::SLOT_SEL_W;

  logic [ENTRIES-1:0] btb_valid;
  logic [TAG_W-1:0]   btb_tag    [ENTRIES];
  logic [31:0]        btb_target [ENTRIES];

  logic [IDX_W-1:0]   upd_idx;
  logic [TAG_W-1:0]   upd_tag;
  logic [31:0]        group_base;
  logic [OFF_W-1:0]   pc_off;
  logic [SLOTS-1:0]   slot_hit;
  logic [31:0]        slot_target [SLOTS];

  assign upd_idx    = update_pc[2 +: IDX_W];
  assign upd_tag    = update_pc[31 -: TAG_W];
  assign group_base = {pc[31:OFF_W+2], {(OFF_W + 2){1'b0}}};
  assign pc_off     = pc[2 +: OFF_W];

  // --------------------------------------------------------------------------
  // per-slot lookup
  // --------------------------------------------------------------------------

  for (genvar g = 0; g < SLOTS; g++) begin : g_slot
    logic [29:0]      waddr;
    logic [IDX_W-1:0] idx;

    assign waddr = {pc[31:OFF_W+2], OFF_W'(g)}; // word address of this slot.
    assign idx   = waddr[IDX_W-1:0];

    assign slot_hit[g]    = btb_valid[idx] && (btb_tag[idx] == waddr[29:IDX_W]);
    assign slot_target[g] = btb_target[idx];
  end

  // the first predicted jump at or after the pc ends the group.
  always_comb begin
    logic found;

    found      = 1'b0;
    is_jump    = '0;
    slot_valid = '0;
    next_pc    = group_base + 32'(fetch_pkg::GROUP_BYTES);
    for (int i = 0; i < SLOTS; i++) begin
      if (!found && (OFF_W'(i) >= pc_off)) begin
        slot_valid[i] = 1'b1;
        if (slot_hit[i]) begin
          is_jump[i] = 1'b1;
          next_pc    = slot_target[i];
          found      = 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // training
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      btb_valid <= '0;
    end else if (update_valid) begin
      btb_valid[upd_idx] <= update_taken; // not taken drops the entry.
    end
  end

  always_ff @(posedge clk) begin
    if (update_valid && update_taken) begin
      btb_tag[upd_idx]    <= upd_tag;
      btb_target[upd_idx] <= update_target;
    end
  end

endmodule

`default_nettype wire

// File: design/if_stage1.sv
`timescale 1ns/100ps
`default_nettype none

module if_stage1 (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   flush,
  input  logic                   if0_valid,
  input  logic [31:0]            if0_pc,
  input  fetch_pkg::slot_mask_t  if0_slot_valid,
  input  fetch_pkg::slot_mask_t  if0_is_jump,
  input  excp_pkg::ecode_t       if0_ecode,
  input  excp_pkg::subcode_t     if0_subcode,
  input  logic                   data_ok,
  input  fetch_pkg::group_data_t rdata,
  input  logic                   out_ready,
  output logic                   if1_ready,
  output logic                   out_valid,
  output logic [31:0]            out_pc,
  output fetch_pkg::group_data_t out_inst,
  output fetch_pkg::slot_mask_t  out_slot_valid,
  output fetch_pkg::slot_mask_t  out_is_jump,
  output excp_pkg::ecode_t       out_ecode,
  output excp_pkg::subcode_t     out_subcode
);

  fetch_pkg::if1_state_t state_r;
  fetch_pkg::if1_state_t state_nxt;

  logic take;
  logic adef_in;
  logic capture_data;

  assign take    = (state_r == fetch_pkg::S_IDLE) && if0_valid;
  assign adef_in = (if0_ecode != excp_pkg::E_NONE);

  // the response may land in the very cycle the group is taken.
  assign capture_data = data_ok && (take || (state_r == fetch_pkg::S_WAIT));

  assign if1_ready = (state_r == fetch_pkg::S_IDLE) ||
                     ((state_r == fetch_pkg::S_HOLD) && out_ready);
  assign out_valid = (state_r == fetch_pkg::S_HOLD);

  // --------------------------------------------------------------------------
  // state machine
  // --------------------------------------------------------------------------

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      fetch_pkg::S_IDLE: begin
        if (take) begin
          if (flush) begin
            state_nxt = (adef_in || data_ok) ? fetch_pkg::S_IDLE : fetch_pkg::S_DROP;
          end else if (adef_in || data_ok) begin
            state_nxt = fetch_pkg::S_HOLD; // nothing left to wait for.
          end else begin
            state_nxt = fetch_pkg::S_WAIT;
          end
        end
      end
      fetch_pkg::S_WAIT: begin
        if (flush) begin
          state_nxt = data_ok ? fetch_pkg::S_IDLE : fetch_pkg::S_DROP;
        end else if (data_ok) begin
          state_nxt = fetch_pkg::S_HOLD;
        end
      end
      fetch_pkg::S_HOLD: begin
        if (flush || out_ready) begin
          state_nxt = fetch_pkg::S_IDLE;
        end
      end
      fetch_pkg::S_DROP: begin
        if (data_ok) begin
          state_nxt = fetch_pkg::S_IDLE; // stale response swallowed.
        end
      end
      default: state_nxt = fetch_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_r <= fetch_pkg::S_IDLE;
    end else begin
      state_r <= state_nxt;
    end
  end

  // --------------------------------------------------------------------------
  // group payload
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (take) begin
      out_pc         <= if0_pc;
      out_slot_valid <= if0_slot_valid;
      out_is_jump    <= if0_is_jump;
      out_ecode      <= if0_ecode;
      out_subcode    <= if0_subcode;
    end
  end

  always_ff @(posedge clk) begin
    if (take && adef_in) begin
      out_inst <= '0; // no memory behind a faulting group.
    end else if (capture_data) begin
      out_inst <= rdata;
    end
  end

endmodule

`default_nettype wire

// File: design/fetch_frontend.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend (
  input  logic                   clk,
  input  logic                   rst,
  output logic                   req,
  output logic [31:0]            addr,
  input  logic                   addr_ok,
  input  logic                   data_ok,
  input  fetch_pkg::group_data_t rdata,
  input  logic                   need_jump,
  input  logic [31:0]            jump_pc,
  input  logic                   flush,
  input  logic                   update_valid,
  input  logic [31:0]            update_pc,
  input  logic [31:0]            update_target,
  input  logic                   update_taken,
  output logic                   out_valid,
  output logic [31:0]            out_pc,
  output fetch_pkg::group_data_t out_inst,
  output fetch_pkg::slot_mask_t  out_slot_valid,
  output fetch_pkg::slot_mask_t  out_is_jump,
  output excp_pkg::ecode_t       out_ecode,
  output excp_pkg::subcode_t     out_subcode,
  input  logic                   out_ready
);

  logic [31:0]           pc_to_bpu;
  fetch_pkg::slot_mask_t pc_is_jump;
  fetch_pkg::slot_mask_t pc_valid;
  logic [31:0]           pre_nextpc;

  logic                  if0_valid;
  logic [31:0]           if0_pc;
  fetch_pkg::slot_mask_t if0_slot_valid;
  fetch_pkg::slot_mask_t if0_is_jump;
  excp_pkg::ecode_t      if0_ecode;
  excp_pkg::subcode_t    if0_subcode;
  logic                  if1_ready;

  if_stage0 if_stage0_i (
    .clk, .rst, .flush, .need_jump, .jump_pc, .addr_ok, .if1_ready,
    .pc_is_jump, .pc_valid, .pre_nextpc, .req, .addr, .pc_to_bpu,
    .if0_valid, .if0_pc, .if0_slot_valid, .if0_is_jump, .if0_ecode, .if0_subcode
  );

  branch_predictor branch_predictor_i (
    .clk, .rst,
    .pc            (pc_to_bpu),
    .update_valid, .update_pc, .update_target, .update_taken,
    .is_jump       (pc_is_jump),
    .slot_valid    (pc_valid),
    .next_pc       (pre_nextpc)
  );

  if_stage1 if_stage1_i (
    .clk, .rst, .flush,
    .if0_valid, .if0_pc, .if0_slot_valid, .if0_is_jump, .if0_ecode, .if0_subcode,
    .data_ok, .rdata, .out_ready, .if1_ready,
    .out_valid, .out_pc, .out_inst, .out_slot_valid, .out_is_jump, .out_ecode,
    .out_subcode
  );

endmodule

`default_nettype wire

// File: testbench/fetch_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_assertions (
  input logic                   clk,
  input logic                   rst,
  input logic                   flush,
  input logic                   req,
  input logic                   data_ok,
  input logic                   if0_valid,
  input fetch_pkg::if1_state_t  state,
  input logic                   out_valid,
  input logic                   out_ready,
  input logic [31:0]            out_pc,
  input fetch_pkg::group_data_t out_inst,
  input fetch_pkg::slot_mask_t  out_slot_valid,
  input fetch_pkg::slot_mask_t  out_is_jump,
  input excp_pkg::ecode_t       out_ecode,
  input excp_pkg::subcode_t     out_subcode
);

  int unsigned fail_cnt;

  initial fail_cnt = 0;

  a_no_req_in_reset: assert property (@(posedge clk) rst |-> !req)
    else begin
      fail_cnt++;
      $error("req is high during reset");
    end

  // a stalled group keeps every field until decode takes it or a flush drops it.
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready && !flush) |=>
      (out_valid && $stable(out_pc) && $stable(out_inst) && $stable(out_slot_valid) &&
       $stable(out_is_jump) && $stable(out_ecode) && $stable(out_subcode)))
    else begin
      fail_cnt++;
      $error("decode outputs changed while out_ready was low");
    end

  a_no_data_in_idle: assert property (@(posedge clk) disable iff (rst)
    data_ok |-> ((state != fetch_pkg::S_IDLE) || if0_valid)) // take cycle may see data.
    else begin
      fail_cnt++;
      $error("data_ok arrived while stage 1 was idle");
    end

endmodule

bind fetch_frontend fetch_assertions fetch_assertions_i (
  .clk, .rst, .flush, .req, .data_ok, .if0_valid,
  .state (if_stage1_i.state_r),
  .out_valid, .out_ready, .out_pc, .out_inst, .out_slot_valid, .out_is_jump,
  .out_ecode, .out_subcode
);

`default_nettype wire

// File: testbench/fetch_tb.sv
`include "fetch_settings.svh"
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;

  localparam int unsigned WAIT_LIMIT = 200; // cycles allowed for any single wait.

  logic                   clk;
  logic                   rst;
  logic                   req;
  logic [31:0]            addr;
  logic                   addr_ok;
  logic                   data_ok;
  fetch_pkg::group_data_t rdata;
  logic                   need_jump;
  logic [31:0]            jump_pc;
  logic                   flush;
  logic                   update_valid;
  logic [31:0]            update_pc;
  logic [31:0]            update_target;
  logic                   update_taken;
  logic                   out_valid;
  logic [31:0]            out_pc;
  fetch_pkg::group_data_t out_inst;
  fetch_pkg::slot_mask_t  out_slot_valid;
  fetch_pkg::slot_mask_t  out_is_jump;
  excp_pkg::ecode_t       out_ecode;
  excp_pkg::subcode_t     out_subcode;
  logic                   out_ready;

  logic [31:0] lcg_state;
  int unsigned cyc;
  int unsigned errors;
  int unsigned timeouts;

  logic [31:0] pend_addr [$]; // accepted requests still owed a response.
  int unsigned pend_due  [$];
  int unsigned last_due;

  logic [31:0]            got_pc        [$]; // groups taken by decode in arrival order.
  fetch_pkg::group_data_t got_inst      [$];
  fetch_pkg::slot_mask_t  got_slot      [$];
  fetch_pkg::slot_mask_t  got_jump      [$];
  excp_pkg::ecode_t       got_ecode     [$];
  excp_pkg::subcode_t     got_subcode   [$];

  logic [31:0]            cur_pc;
  fetch_pkg::group_data_t cur_inst;
  fetch_pkg::slot_mask_t  cur_slot;
  fetch_pkg::slot_mask_t  cur_jump;
  excp_pkg::ecode_t       cur_ecode;
  excp_pkg::subcode_t     cur_subcode;

  fetch_frontend fetch_frontend_i (.*);

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // each memory word is its word address with a fixed pattern on top.
  function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
    return {2'b00, byte_addr[31:2]} ^ 32'ha5a5_0000;
  endfunction

  function automatic fetch_pkg::group_data_t line_data(input logic [31:0] a);
    fetch_pkg::group_data_t d;
    logic [31:0]            base;
    base = {a[31:4], 4'h0};
    for (int i = 0; i < 4; i++) begin
      d[i*32 +: 32] = mem_word(base + 32'(4 * i));
    end
    return d;
  endfunction

  // --------------------------------------------------------------------------
  // cache model and decode-side monitor
  // --------------------------------------------------------------------------

  always begin : cache_model
    logic [31:0] r;
    int unsigned due;
    @(posedge clk);
    #5;
    cyc     = cyc + 1;
    r       = lcg_next();
    addr_ok = (r[17:16] != 2'b00);
    data_ok = 1'b0;
    if ((pend_due.size() > 0) && (pend_due[0] <= cyc)) begin
      data_ok = 1'b1;
      rdata   = line_data(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end
    @(negedge clk);
    if (req && addr_ok) begin
      due = cyc + 1 + r[21:20]; // one to four cycles after acceptance.
      if (due <= last_due) begin
        due = last_due + 1;
      end
      pend_addr.push_back(addr);
      pend_due.push_back(due);
      last_due = due;
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      if (req && (addr[1:0] != 2'b00)) begin
        errors++;
        $display("a cache request was issued for the misaligned address 0x%h", addr);
      end
      if (out_valid && out_ready) begin
        got_pc.push_back(out_pc);
        got_inst.push_back(out_inst);
        got_slot.push_back(out_slot_valid);
        got_jump.push_back(out_is_jump);
        got_ecode.push_back(out_ecode);
        got_subcode.push_back(out_subcode);
      end
    end
  end

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------

  task automatic check_pc(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input fetch_pkg::group_data_t got,
                            input fetch_pkg::group_data_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_mask(input string name, input fetch_pkg::slot_mask_t got,
                            input fetch_pkg::slot_mask_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_ecode(input string name, input excp_pkg::ecode_t got,
                             input excp_pkg::ecode_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_subcode(input string name, input excp_pkg::subcode_t got,
                               input excp_pkg::subcode_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // --------------------------------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------------------------------

  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic clear_groups();
    got_pc.delete();
    got_inst.delete();
    got_slot.delete();
    got_jump.delete();
    got_ecode.delete();
    got_subcode.delete();
  endtask

  task automatic take_group(output logic ok);
    int unsigned n;
    n = 0;
    while ((got_pc.size() == 0) && (n < WAIT_LIMIT)) begin
      @(posedge clk);
      n++;
    end
    ok = (got_pc.size() != 0);
    if (!ok) begin
      timeouts++;
      $display("timeout: no group reached decode within %0d cycles", WAIT_LIMIT);
    end else begin
      cur_pc      = got_pc.pop_front();
      cur_inst    = got_inst.pop_front();
      cur_slot    = got_slot.pop_front();
      cur_jump    = got_jump.pop_front();
      cur_ecode   = got_ecode.pop_front();
      cur_subcode = got_subcode.pop_front();
    end
  endtask

  task automatic expect_group(input logic [31:0] pc, input fetch_pkg::slot_mask_t mask,
                              input fetch_pkg::slot_mask_t jmp);
    logic ok;
    take_group(ok);
    if (ok) begin
      check_pc("out_pc", cur_pc, pc);
      check_data("out_inst", cur_inst, line_data(pc));
      check_mask("out_slot_valid", cur_slot, mask);
      check_mask("out_is_jump", cur_jump, jmp);
      check_ecode("out_ecode", cur_ecode, excp_pkg::E_NONE);
      check_subcode("out_subcode", cur_subcode, '0);
    end
  endtask

  task automatic redirect(input logic [31:0] target);
    next_cycle();
    need_jump = 1'b1;
    flush     = 1'b1;
    jump_pc   = target;
    next_cycle();
    need_jump = 1'b0;
    flush     = 1'b0;
    clear_groups(); // anything older belongs to the flushed path.
  endtask

  task automatic train(input logic [31:0] pc, input logic [31:0] target, input logic taken);
    next_cycle();
    update_valid  = 1'b1;
    update_pc     = pc;
    update_target = target;
    update_taken  = taken;
    next_cycle();
    update_valid  = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------

  task automatic after_reset_fetch();
    expect_group(`FETCH_RESET_PC, 4'b1111, 4'b0000);
  endtask

  task automatic sequential_fetch();
    for (int i = 1; i <= 6; i++) begin
      expect_group(`FETCH_RESET_PC + 32'(16 * i), 4'b1111, 4'b0000);
    end
  endtask

  task automatic redirect_into_group();
    redirect(32'h1c00_1008);
    expect_group(32'h1c00_1008, 4'b1100, 4'b0000); // entry at slot 2.
    expect_group(32'h1c00_1010, 4'b1111, 4'b0000);
  endtask

  task automatic predicted_jump();
    train(32'h1c00_2004, 32'h1c00_3000, 1'b1);
    redirect(32'h1c00_2000);
    expect_group(32'h1c00_2000, 4'b0011, 4'b0010);
    expect_group(32'h1c00_3000, 4'b1111, 4'b0000);
    train(32'h1c00_2004, 32'h0, 1'b0);
    redirect(32'h1c00_2000);
    expect_group(32'h1c00_2000, 4'b1111, 4'b0000);
    expect_group(32'h1c00_2010, 4'b1111, 4'b0000);
  endtask

  task automatic misaligned_redirect();
    logic ok;
    redirect(32'h1c00_4002);
    take_group(ok);
    if (ok) begin
      check_pc("out_pc", cur_pc, 32'h1c00_4002);
      check_ecode("out_ecode", cur_ecode, excp_pkg::E_ADEF);
      check_subcode("out_subcode", cur_subcode, '0);
    end
    expect_group(32'h1c00_4010, 4'b1111, 4'b0000);
  endtask

  task automatic decode_backpressure();
    int unsigned            n;
    logic [31:0]            held_pc;
    fetch_pkg::group_data_t held_inst;
    fetch_pkg::slot_mask_t  held_slot;
    excp_pkg::ecode_t       held_ecode;
    next_cycle();
    out_ready = 1'b0;
    redirect(32'h1c00_5000);
    n = 0;
    while (!out_valid && (n < WAIT_LIMIT)) begin
      @(negedge clk);
      n++;
    end
    if (!out_valid) begin
      timeouts++;
      $display("timeout: out_valid never rose while decode was stalled");
    end else begin
      held_pc    = out_pc;
      held_inst  = out_inst;
      held_slot  = out_slot_valid;
      held_ecode = out_ecode;
      repeat (6) begin
        @(negedge clk);
        if (!out_valid) begin
          errors++;
          $display("out_valid dropped while out_ready was low");
        end
        check_pc("out_pc", out_pc, held_pc);
        check_data("out_inst", out_inst, held_inst);
        check_mask("out_slot_valid", out_slot_valid, held_slot);
        check_ecode("out_ecode", out_ecode, held_ecode);
      end
    end
    next_cycle();
    out_ready = 1'b1;
    expect_group(32'h1c00_5000, 4'b1111, 4'b0000);
    expect_group(32'h1c00_5010, 4'b1111, 4'b0000);
    expect_group(32'h1c00_5020, 4'b1111, 4'b0000);
  endtask

  initial begin
    int unsigned asrt;
    clk           = 1'b0;
    rst           = 1'b1;
    addr_ok       = 1'b0;
    data_ok       = 1'b0;
    rdata         = '0;
    need_jump     = 1'b0;
    jump_pc       = 32'h0;
    flush         = 1'b0;
    update_valid  = 1'b0;
    update_pc     = 32'h0;
    update_target = 32'h0;
    update_taken  = 1'b0;
    out_ready     = 1'b1;
    lcg_state     = 32'h4f43;
    cyc           = 0;
    errors        = 0;
    timeouts      = 0;
    last_due      = 0;
    repeat (8) next_cycle();
    rst = 1'b0;
    after_reset_fetch();
    sequential_fetch();
    redirect_into_group();
    predicted_jump();
    misaligned_redirect();
    decode_backpressure();
    repeat (4) next_cycle();
    asrt = fetch_frontend_i.fetch_assertions_i.fail_cnt;
    $display("fetch_tb: %0d errors, %0d timeouts, %0d assertion failures",
             errors, timeouts, asrt);
    if ((errors == 0) && (timeouts == 0) && (asrt == 0)) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+design
design/fetch_pkg.sv
design/excp_pkg.sv
design/if_stage0.sv
design/branch_predictor.sv
design/if_stage1.sv
design/fetch_frontend.sv
testbench/fetch_assertions.sv
testbench/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_frontend

export_include_dirs:
  - design

sources:
  - files:
      - design/fetch_pkg.sv
      - design/excp_pkg.sv
      - design/if_stage0.sv
      - design/branch_predictor.sv
      - design/if_stage1.sv
      - design/fetch_frontend.sv
  - target: test
    files:
      - testbench/fetch_assertions.sv
      - testbench/fetch_tb.sv
